// File: verilog/pipeline_pkg.sv
`default_nettype none

package pipeline_pkg;

    // ########################################
    // widths and memory sizes
    // ########################################

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);  // word index, pc bits 7:2.
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

    // ########################################
    // encodings
    // ########################################

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_HALT  = 6'h3f;

    // funct field of r-type.
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_e;

    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

    // ########################################
    // stage latches
    // ########################################

    typedef struct packed {
        word_t instruction;
        word_t pc;
    } if_id_t;

    typedef struct packed {
        word_t     ra;
        word_t     rb;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        word_t     imm;
        alu_op_e   alu_op;
        logic      alu_src_imm;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      is_halt;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      is_halt;
    } ex_mem_t;

    typedef struct packed {
        word_t     write_data;
        reg_addr_t dest;
        logic      reg_write;
        logic      is_halt;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: verilog/instruction_fetch.sv
`default_nettype none

module instruction_fetch
    import pipeline_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst,
    input  wire        i_halt,
    input  wire        i_stall,
    input  wire        i_program_end,
    input  wire        i_jump,
    input  wire word_t i_jump_address,
    input  wire        i_write_instruction_flag,
    input  wire word_t i_instruction_to_write,
    input  wire word_t i_address_to_write_inst,
    output if_id_t     o_if_id
);

    word_t imem [IMEM_DEPTH];
    word_t pc;
    word_t fetched;
    logic  fetch_done;  // a halt is already in flight.

    assign fetched = imem[pc[IMEM_AW+1:2]];

    // load port works while halted.
    always_ff @(posedge i_clk) begin
        if (i_write_instruction_flag) begin
            imem[i_address_to_write_inst[IMEM_AW+1:2]] <= i_instruction_to_write;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc         <= '0;
            fetch_done <= 1'b0;
            o_if_id    <= '0;
        end else if (!i_halt) begin
            if (i_jump) begin
                pc      <= i_jump_address;
                o_if_id <= '0;  // drop the slot behind j.
            end else if (i_program_end || fetch_done) begin
                o_if_id <= '0;  // nothing past a halt.
            end else if (!i_stall) begin
                o_if_id.instruction <= fetched;
                o_if_id.pc          <= pc;
                pc                  <= pc + 32'd4;
                fetch_done          <= (fetched[31:26] == OP_HALT);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/instruction_decode.sv
`default_nettype none

module instruction_decode
    import pipeline_pkg::*;
(
    input  wire          i_clk,
    input  wire          i_rst,
    input  wire          i_halt,
    input  wire          i_stall,
    input  wire if_id_t  i_if_id,
    input  wire mem_wb_t i_mem_wb,
    output reg_addr_t    o_rs,
    output reg_addr_t    o_rt,
    output logic         o_jump,
    output word_t        o_jump_address,
    output id_ex_t       o_id_ex
);

    word_t      regs [32];
    opcode_t    opcode;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [5:0] funct;
    logic [15:0] imm16;
    logic [25:0] target;
    logic       uses_rs;
    logic       uses_rt;
    id_ex_t     id_ex_next;

    assign opcode = i_if_id.instruction[31:26];
    assign rs     = i_if_id.instruction[25:21];
    assign rt     = i_if_id.instruction[20:16];
    assign rd     = i_if_id.instruction[15:11];
    assign funct  = i_if_id.instruction[5:0];
    assign imm16  = i_if_id.instruction[15:0];
    assign target = i_if_id.instruction[25:0];

    // write-first read, so a writeback this cycle is visible.
    function automatic word_t read_reg(reg_addr_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (i_mem_wb.reg_write && i_mem_wb.dest == idx) begin
            return i_mem_wb.write_data;
        end
        return regs[idx];
    endfunction

    // ########################################
    // control decode
    // ########################################

    always_comb begin
        id_ex_next     = '0;
        uses_rs        = 1'b0;
        uses_rt        = 1'b0;
        id_ex_next.imm = {{16{imm16[15]}}, imm16};
        case (opcode)
            OP_RTYPE: begin
                uses_rs              = 1'b1;
                uses_rt              = 1'b1;
                id_ex_next.dest      = rd;
                id_ex_next.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: id_ex_next.alu_op = ALU_ADD;
                    FN_SUBU: id_ex_next.alu_op = ALU_SUB;
                    FN_AND:  id_ex_next.alu_op = ALU_AND;
                    FN_OR:   id_ex_next.alu_op = ALU_OR;
                    FN_SLT:  id_ex_next.alu_op = ALU_SLT;
                    default: begin
                        uses_rs              = 1'b0;  // unknown funct is a nop.
                        uses_rt              = 1'b0;
                        id_ex_next.reg_write = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_LW: begin
                uses_rs                = 1'b1;
                id_ex_next.dest        = rt;
                id_ex_next.alu_src_imm = 1'b1;
                id_ex_next.reg_write   = 1'b1;
                id_ex_next.mem_read    = (opcode == OP_LW);
            end
            OP_SW: begin
                uses_rs                = 1'b1;
                uses_rt                = 1'b1;
                id_ex_next.alu_src_imm = 1'b1;
                id_ex_next.mem_write   = 1'b1;
            end
            OP_HALT: id_ex_next.is_halt = 1'b1;
            default: ;
        endcase
        // unused fields read as r0, which never stalls or forwards.
        id_ex_next.rs = uses_rs ? rs : '0;
        id_ex_next.rt = uses_rt ? rt : '0;
        id_ex_next.ra = read_reg(id_ex_next.rs);
        id_ex_next.rb = read_reg(id_ex_next.rt);
    end

    assign o_rs           = id_ex_next.rs;
    assign o_rt           = id_ex_next.rt;
    assign o_jump         = (opcode == OP_J);
    assign o_jump_address = {i_if_id.pc[31:28], target, 2'b00};

    always_ff @(posedge i_clk) begin
        if (i_mem_wb.reg_write && i_mem_wb.dest != '0) begin
            regs[i_mem_wb.dest] <= i_mem_wb.write_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_id_ex <= '0;
        end else if (!i_halt) begin
            if (i_stall) begin
                o_id_ex <= '0;  // bubble.
            end else begin
                o_id_ex <= id_ex_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/hazard_unit.sv
`default_nettype none

module hazard_unit
    import pipeline_pkg::*;
(
    input  wire reg_addr_t i_rs_id,
    input  wire reg_addr_t i_rt_id,
    input  wire id_ex_t    i_id_ex,
    input  wire ex_mem_t   i_ex_mem,
    input  wire mem_wb_t   i_mem_wb,
    output fwd_sel_e       o_fwd_a,
    output fwd_sel_e       o_fwd_b,
    output logic           o_stall
);

    // ########################################
    // forwarding into execute
    // ########################################

    // the younger result in mem wins over wb.
    function automatic fwd_sel_e pick_fwd(reg_addr_t src, ex_mem_t ex_mem, mem_wb_t mem_wb);
        if (src == '0) begin
            return FWD_NONE;
        end
        if (ex_mem.reg_write && ex_mem.dest == src) begin
            return FWD_MEM;
        end
        if (mem_wb.reg_write && mem_wb.dest == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign o_fwd_a = pick_fwd(i_id_ex.rs, i_ex_mem, i_mem_wb);
    assign o_fwd_b = pick_fwd(i_id_ex.rt, i_ex_mem, i_mem_wb);

    // ########################################
    // load-use stall
    // ########################################

    logic load_in_ex;

    assign load_in_ex = i_id_ex.mem_read && (i_id_ex.dest != '0);

    assign o_stall = load_in_ex
                  && ((i_id_ex.dest == i_rs_id) || (i_id_ex.dest == i_rt_id));

endmodule

`default_nettype wire

// File: verilog/instruction_exec.sv
`default_nettype none

module instruction_exec
    import pipeline_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_rst,
    input  wire           i_halt,
    input  wire id_ex_t   i_id_ex,
    input  wire fwd_sel_e i_fwd_a,
    input  wire fwd_sel_e i_fwd_b,
    input  wire word_t    i_mem_forward,
    input  wire word_t    i_wb_forward,
    output ex_mem_t       o_ex_mem
);

    word_t op_a;
    word_t op_b;
    word_t rt_val;
    word_t alu_result;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val,
                                      word_t mem_val, word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a   = fwd_mux(i_fwd_a, i_id_ex.ra, i_mem_forward, i_wb_forward);
    assign rt_val = fwd_mux(i_fwd_b, i_id_ex.rb, i_mem_forward, i_wb_forward);
    assign op_b   = i_id_ex.alu_src_imm ? i_id_ex.imm : rt_val;

    // ########################################
    // alu
    // ########################################

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};  // signed.
            default: alu_result = op_a + op_b;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ex_mem <= '0;
        end else if (!i_halt) begin
            o_ex_mem.alu_result <= alu_result;
            o_ex_mem.store_data <= rt_val;  // forwarded rt for sw.
            o_ex_mem.dest       <= i_id_ex.dest;
            o_ex_mem.mem_read   <= i_id_ex.mem_read;
            o_ex_mem.mem_write  <= i_id_ex.mem_write;
            o_ex_mem.reg_write  <= i_id_ex.reg_write;
            o_ex_mem.is_halt    <= i_id_ex.is_halt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/instruction_mem.sv
`default_nettype none

module instruction_mem
    import pipeline_pkg::*;
(
    input  wire          i_clk,
    input  wire          i_rst,
    input  wire          i_halt,
    input  wire ex_mem_t i_ex_mem,
    output mem_wb_t      o_mem_wb,
    output logic         o_program_end
);

    word_t              dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] addr;
    word_t              read_data;
    word_t              write_data;

    assign addr      = i_ex_mem.alu_result[DMEM_AW+1:2];  // whole words only.
    assign read_data = dmem[addr];

    // writeback select.
    assign write_data = i_ex_mem.mem_read ? read_data : i_ex_mem.alu_result;

    always_ff @(posedge i_clk) begin
        if (!i_halt && i_ex_mem.mem_write) begin
            dmem[addr] <= i_ex_mem.store_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_mem_wb      <= '0;
            o_program_end <= 1'b0;
        end else if (!i_halt) begin
            o_mem_wb.write_data <= write_data;
            o_mem_wb.dest       <= i_ex_mem.dest;
            o_mem_wb.reg_write  <= i_ex_mem.reg_write;
            o_mem_wb.is_halt    <= i_ex_mem.is_halt;
            if (i_ex_mem.is_halt) begin
                o_program_end <= 1'b1;  // sticky until reset.
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/pipeline.sv
`default_nettype none

module pipeline
    import pipeline_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst,
    input  wire        i_halt,
    input  wire        i_write_instruction_flag,
    input  wire word_t i_instruction_to_write,
    input  wire word_t i_address_to_write_inst,
    output if_id_t     o_if_id,
    output id_ex_t     o_id_ex,
    output ex_mem_t    o_ex_mem,
    output mem_wb_t    o_mem_wb,
    output logic       o_program_end
);

    // ########################################
    // stage latches and controls
    // ########################################

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;

    reg_addr_t rs_id;
    reg_addr_t rt_id;
    logic      jump;
    word_t     jump_address;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    logic      stall;
    logic      program_end;

    instruction_fetch u_instruction_fetch (
        .i_clk                    (i_clk),
        .i_rst                    (i_rst),
        .i_halt                   (i_halt),
        .i_stall                  (stall),
        .i_program_end            (program_end),
        .i_jump                   (jump),
        .i_jump_address           (jump_address),
        .i_write_instruction_flag (i_write_instruction_flag),
        .i_instruction_to_write   (i_instruction_to_write),
        .i_address_to_write_inst  (i_address_to_write_inst),
        .o_if_id                  (if_id)
    );

    instruction_decode u_instruction_decode (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_halt         (i_halt),
        .i_stall        (stall),
        .i_if_id        (if_id),
        .i_mem_wb       (mem_wb),
        .o_rs           (rs_id),
        .o_rt           (rt_id),
        .o_jump         (jump),
        .o_jump_address (jump_address),
        .o_id_ex        (id_ex)
    );

    hazard_unit u_hazard_unit (
        .i_rs_id  (rs_id),
        .i_rt_id  (rt_id),
        .i_id_ex  (id_ex),
        .i_ex_mem (ex_mem),
        .i_mem_wb (mem_wb),
        .o_fwd_a  (fwd_a),
        .o_fwd_b  (fwd_b),
        .o_stall  (stall)
    );

    instruction_exec u_instruction_exec (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_halt        (i_halt),
        .i_id_ex       (id_ex),
        .i_fwd_a       (fwd_a),
        .i_fwd_b       (fwd_b),
        .i_mem_forward (ex_mem.alu_result),
        .i_wb_forward  (mem_wb.write_data),
        .o_ex_mem      (ex_mem)
    );

    instruction_mem u_instruction_mem (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_halt        (i_halt),
        .i_ex_mem      (ex_mem),
        .o_mem_wb      (mem_wb),
        .o_program_end (program_end)
    );

    assign o_if_id       = if_id;
    assign o_id_ex       = id_ex;
    assign o_ex_mem      = ex_mem;
    assign o_mem_wb      = mem_wb;
    assign o_program_end = program_end;

endmodule

`default_nettype wire

// File: tests/pipeline_sva.sv
`default_nettype none

module pipeline_sva
    import pipeline_pkg::*;
(
    input wire          i_clk,
    input wire          i_rst,
    input wire          i_halt,
    input wire if_id_t  i_if_id,
    input wire id_ex_t  i_id_ex,
    input wire ex_mem_t i_ex_mem,
    input wire mem_wb_t i_mem_wb,
    input wire          i_program_end
);

    logic controls_set;

    assign controls_set = (i_if_id != '0)
                       || i_id_ex.reg_write || i_id_ex.mem_read || i_id_ex.mem_write
                       || i_id_ex.is_halt
                       || i_ex_mem.reg_write || i_ex_mem.mem_read || i_ex_mem.mem_write
                       || i_ex_mem.is_halt
                       || i_mem_wb.reg_write || i_mem_wb.is_halt || i_program_end;

    // latches come out of reset empty.
    assert property (@(posedge i_clk) $fell(i_rst) |-> !controls_set)
        else $error("a latch control is set in the first cycle after reset");

    assert property (@(posedge i_clk) i_program_end && !i_rst |=> i_program_end)
        else $error("program end flag fell without a reset");

    assert property (@(posedge i_clk) i_halt && !i_rst |=> $stable(i_if_id))
        else $error("fetch latch changed while the pipeline was halted");

endmodule

bind pipeline pipeline_sva pipeline_sva_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_halt        (i_halt),
    .i_if_id       (o_if_id),
    .i_id_ex       (o_id_ex),
    .i_ex_mem      (o_ex_mem),
    .i_mem_wb      (o_mem_wb),
    .i_program_end (o_program_end)
);

`default_nettype wire

// File: tests/pipeline_tb.sv
`default_nettype none

module pipeline_tb
    import pipeline_pkg::*;
();

    logic    clk;
    logic    rst;
    logic    halt;
    logic    write_flag;
    word_t   instr_to_write;
    word_t   addr_to_write;
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    logic    program_end;

    word_t     prog [$];
    reg_addr_t exp_dest [$];
    word_t     exp_data [$];
    reg_addr_t got_dest [$];
    word_t     got_data [$];
    int        stalls;
    int        errors;

    pipeline pipeline_inst (
        .i_clk                    (clk),
        .i_rst                    (rst),
        .i_halt                   (halt),
        .i_write_instruction_flag (write_flag),
        .i_instruction_to_write   (instr_to_write),
        .i_address_to_write_inst  (addr_to_write),
        .o_if_id                  (if_id),
        .o_id_ex                  (id_ex),
        .o_ex_mem                 (ex_mem),
        .o_mem_wb                 (mem_wb),
        .o_program_end            (program_end)
    );

    always #5 clk = ~clk;

    // ########################################
    // encoding and checking
    // ########################################

    function automatic word_t rtype_word(logic [5:0] funct, reg_addr_t rd, reg_addr_t rs,
                                         reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t itype_word(opcode_t op, reg_addr_t rt, reg_addr_t rs,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic int count_dest(reg_addr_t r);
        int n;
        n = 0;
        foreach (got_dest[i]) begin
            if (got_dest[i] == r) n++;
        end
        return n;
    endfunction

    // ########################################
    // reference model
    // ########################################

    // executes the program in order and lists every register write.
    task automatic predict_writes();
        word_t     regs [32];
        word_t     dmem [64];
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     ea;
        word_t     res;
        reg_addr_t dst;
        logic      wr;
        logic      done;
        int        idx;
        int        steps;
        exp_dest.delete();
        exp_data.delete();
        foreach (regs[r]) regs[r] = '0;
        idx   = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 200) begin
            ins = (idx < prog.size()) ? prog[idx] : '0;  // padding is a nop.
            a   = regs[ins[25:21]];
            b   = regs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            ea  = a + imm;
            dst = ins[20:16];
            res = '0;
            wr  = 1'b0;
            idx++;
            steps++;
            case (ins[31:26])
                OP_RTYPE: begin
                    dst = ins[15:11];
                    wr  = 1'b1;
                    case (ins[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: begin
                    wr  = 1'b1;
                    res = ea;
                end
                OP_LW: begin
                    wr  = 1'b1;
                    res = dmem[ea[7:2]];
                end
                OP_SW:   dmem[ea[7:2]] = b;
                OP_J:    idx = {6'd0, ins[25:0]};  // pc upper bits stay zero.
                OP_HALT: done = 1'b1;
                default: ;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_dest.push_back(dst);
                exp_data.push_back(res);
            end
        end
    endtask

    // ########################################
    // driving the dut
    // ########################################

    task automatic load_program();
        int i;
        @(negedge clk);
        halt = 1'b1;
        for (i = 0; i < IMEM_DEPTH; i++) begin
            write_flag     = 1'b1;
            addr_to_write  = i << 2;
            instr_to_write = (i < prog.size()) ? prog[i] : '0;
            @(negedge clk);
        end
        write_flag = 1'b0;
        rst        = 1'b1;
        repeat (2) @(negedge clk);
        rst  = 1'b0;
        halt = 1'b0;
    endtask

    // records writes until the end flag, optionally holding halt for a while.
    task automatic collect(input string name, input int halt_at, input int halt_len);
        int     cycle;
        logic   moved;
        if_id_t prev_if_id;
        got_dest.delete();
        got_data.delete();
        cycle      = 0;
        moved      = 1'b1;
        stalls     = 0;
        prev_if_id = '0;
        while (!program_end && cycle < 200) begin
            @(negedge clk);
            if (moved && mem_wb.reg_write && mem_wb.dest != 5'd0) begin
                got_dest.push_back(mem_wb.dest);
                got_data.push_back(mem_wb.write_data);
            end
            if (moved && if_id != '0 && if_id == prev_if_id && id_ex == '0) begin
                stalls++;  // fetch held while a bubble went to execute.
            end
            prev_if_id = if_id;
            if (halt_len > 0 && cycle == halt_at) halt = 1'b1;
            if (halt_len > 0 && cycle == halt_at + halt_len) halt = 1'b0;
            moved = !halt;  // a held latch is not a new write.
            cycle++;
        end
        halt = 1'b0;
        if (!program_end) begin
            $display("ERROR: %s did not reach program end within 200 cycles", name);
            errors++;
        end
    endtask

    task automatic compare_streams(input string name);
        int i;
        check({name, " write count"}, exp_dest.size(), got_dest.size());
        for (i = 0; i < exp_dest.size() && i < got_dest.size(); i++) begin
            check($sformatf("%s write %0d dest", name, i), {27'd0, exp_dest[i]},
                  {27'd0, got_dest[i]});
            check($sformatf("%s write %0d data", name, i), exp_data[i], got_data[i]);
        end
    endtask

    task automatic execute_program(input string name, input int halt_at, input int halt_len);
        predict_writes();
        load_program();
        collect(name, halt_at, halt_len);
        compare_streams(name);
    endtask

    // ########################################
    // directed tests
    // ########################################

    task automatic alu_ops();
        prog.delete();
        prog.push_back(itype_word(OP_ADDIU, 5'd1, 5'd0, 16'd25));
        prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd0, 16'hfff9));  // -7.
        prog.push_back(rtype_word(FN_ADDU, 5'd3, 5'd1, 5'd2));
        prog.push_back(rtype_word(FN_SUBU, 5'd4, 5'd1, 5'd2));
        prog.push_back(rtype_word(FN_AND, 5'd5, 5'd1, 5'd2));
        prog.push_back(rtype_word(FN_OR, 5'd6, 5'd1, 5'd2));
        prog.push_back(rtype_word(FN_SLT, 5'd7, 5'd2, 5'd1));
        prog.push_back(rtype_word(FN_SLT, 5'd8, 5'd1, 5'd2));
        prog.push_back({OP_HALT, 26'd0});
        execute_program("alu", 0, 0);
    endtask

    task automatic forwarding();
        prog.delete();
        prog.push_back(itype_word(OP_ADDIU, 5'd1, 5'd0, 16'd5));
        prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd0, 16'd9));
        prog.push_back(itype_word(OP_ADDIU, 5'd3, 5'd0, 16'd100));
        prog.push_back(rtype_word(FN_ADDU, 5'd4, 5'd1, 5'd1));  // distance three.
        prog.push_back(rtype_word(FN_ADDU, 5'd5, 5'd2, 5'd4));  // distance one.
        prog.push_back(rtype_word(FN_ADDU, 5'd6, 5'd4, 5'd3));  // distance two.
        prog.push_back(rtype_word(FN_ADDU, 5'd7, 5'd6, 5'd5));
        prog.push_back({OP_HALT, 26'd0});
        execute_program("forwarding", 0, 0);
        check("forwarding stall cycles", 32'd0, stalls);  // no loads here.
    endtask

    task automatic build_mem_program();
        prog.delete();
        prog.push_back(itype_word(OP_ADDIU, 5'd1, 5'd0, 16'd16));
        prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd0, 16'd77));
        prog.push_back(itype_word(OP_SW, 5'd2, 5'd1, 16'd4));
        prog.push_back(itype_word(OP_LW, 5'd3, 5'd1, 16'd4));
        prog.push_back(rtype_word(FN_ADDU, 5'd4, 5'd3, 5'd2));  // load-use.
        prog.push_back(itype_word(OP_LW, 5'd5, 5'd1, 16'd4));
        prog.push_back(rtype_word(FN_SUBU, 5'd6, 5'd5, 5'd5));
        prog.push_back(rtype_word(FN_OR, 5'd7, 5'd4, 5'd6));
        prog.push_back({OP_HALT, 26'd0});
    endtask

    task automatic load_store_hazard();
        build_mem_program();
        execute_program("load store", 0, 0);
        check("load store stall cycles", 32'd2, stalls);  // two load-use pairs.
    endtask

    task automatic jump_skip();
        prog.delete();
        prog.push_back(itype_word(OP_ADDIU, 5'd1, 5'd0, 16'd1));
        prog.push_back({OP_J, 26'd4});
        prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd0, 16'd2));
        prog.push_back(itype_word(OP_ADDIU, 5'd3, 5'd0, 16'd3));
        prog.push_back(itype_word(OP_ADDIU, 5'd4, 5'd1, 16'd4));  // target.
        prog.push_back({OP_HALT, 26'd0});
        execute_program("jump", 0, 0);
        check("jump skipped r2", 32'd0, count_dest(5'd2));
        check("jump skipped r3", 32'd0, count_dest(5'd3));
        check("jump target r4", 32'd1, count_dest(5'd4));
    endtask

    task automatic halt_and_end();
        int quiet_writes;
        int end_low;
        build_mem_program();
        execute_program("halt", 5, 20);
        quiet_writes = 0;
        end_low      = 0;
        repeat (20) begin
            @(negedge clk);
            if (mem_wb.reg_write && mem_wb.dest != 5'd0) quiet_writes++;
            if (!program_end) end_low++;
        end
        check("halt writes after end", 32'd0, quiet_writes);
        check("halt end flag low cycles", 32'd0, end_low);
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        halt           = 1'b1;
        write_flag     = 1'b0;
        instr_to_write = '0;
        addr_to_write  = '0;
        errors         = 0;
        stalls         = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        alu_ops();
        forwarding();
        load_store_hazard();
        jump_skip();
        halt_and_end();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/pipeline_pkg.sv
verilog/instruction_fetch.sv
verilog/instruction_decode.sv
verilog/hazard_unit.sv
verilog/instruction_exec.sv
verilog/instruction_mem.sv
verilog/pipeline.sv
tests/pipeline_sva.sv
tests/pipeline_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module pipeline_tb -f sim.f -o pipeline_sim &&
out="$(./obj_dir/pipeline_sim 2>&1)"
echo "$out"
echo "$out" | grep -qF "Simulation completed successfully" && exit 0 || exit 1
